/* common/core_pkg.sv */
package core_pkg;

    typedef logic [63:0] xlen_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [7:0]  byte_mask_t;
    typedef logic [1:0]  fwd_sel_t;

    localparam xlen_t RESET_PC = 64'h0;
    // addi x0, x0, 0
    localparam inst_t NOP_INST = 32'h0000_0013;

    localparam logic [6:0] OPC_OP        = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_OP_32     = 7'b0111011;
    localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
    localparam logic [6:0] OPC_LOAD      = 7'b0000011;
    localparam logic [6:0] OPC_STORE     = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH    = 7'b1100011;
    localparam logic [6:0] OPC_JAL       = 7'b1101111;
    localparam logic [6:0] OPC_JALR      = 7'b1100111;
    localparam logic [6:0] OPC_LUI       = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC     = 7'b0010111;

    // operand source in execute
    localparam fwd_sel_t FWD_REG = 2'd0;
    localparam fwd_sel_t FWD_MEM = 2'd1;
    localparam fwd_sel_t FWD_WB  = 2'd2;

    typedef enum logic [4:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL, ALU_SRA,
        ALU_OR, ALU_AND, ALU_ADDW, ALU_SUBW, ALU_SLLW, ALU_SRLW, ALU_SRAW
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU, BR_JUMP
    } br_op_e;

    // values follow funct3 of loads and stores
    typedef enum logic [2:0] {
        MW_B, MW_H, MW_W, MW_D, MW_BU, MW_HU, MW_WU
    } mem_width_e;

    typedef enum logic [1:0] {
        WB_ALU, WB_MEM, WB_PC4
    } wb_sel_e;

    typedef struct packed {
        alu_op_e    alu_op;
        br_op_e     br_op;
        mem_width_e mem_width;
        wb_sel_e    wb_sel;
        logic       a_pc;
        logic       b_imm;
        logic       reg_we;
        logic       mem_we;
        logic       mem_re;
    } ctrl_t;

    typedef struct packed {
        logic  valid;
        xlen_t pc;
        inst_t inst;
    } if_id_t;

    localparam if_id_t IF_BUBBLE = '{valid: 1'b0, pc: RESET_PC, inst: NOP_INST};

    typedef struct packed {
        logic     valid;
        ctrl_t    ctrl;
        xlen_t    pc;
        inst_t    inst;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        xlen_t    imm;
        xlen_t    rs1_val;
        xlen_t    rs2_val;
    } id_ex_t;

    typedef struct packed {
        logic       valid;
        ctrl_t      ctrl;
        xlen_t      pc;
        inst_t      inst;
        reg_idx_t   rd;
        xlen_t      result;
        xlen_t      wdata;
        byte_mask_t wmask;
    } ex_mem_t;

    typedef struct packed {
        logic     valid;
        xlen_t    pc;
        inst_t    inst;
        reg_idx_t rd;
        logic     rd_we;
        xlen_t    rd_data;
    } commit_t;

endpackage

/* src/fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage import core_pkg::*; (
    input  logic   clk,
    input  logic   arst_n,
    input  logic   hold,
    input  logic   flush,
    input  logic   redirect,
    input  xlen_t  target,
    output xlen_t  pc,
    input  inst_t  inst,
    output if_id_t if_id
);

    // a redirect from execute wins over any front-end hold
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= RESET_PC;
        end else if (redirect) begin
            pc <= target;
        end else if (!hold) begin
            pc <= pc + 64'd4;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            if_id <= IF_BUBBLE;
        end else if (flush) begin
            // wrong-path slot
            if_id <= IF_BUBBLE;
        end else if (!hold) begin
            if_id.valid <= 1'b1;
            if_id.pc    <= pc;
            if_id.inst  <= inst;
        end
    end

endmodule

/* decode/decoder.sv */
`timescale 1ns/1ps

module decoder import core_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  if_id_t   if_id,
    input  xlen_t    rs1_data,
    input  xlen_t    rs2_data,
    output reg_idx_t rs1,
    output reg_idx_t rs2,
    input  logic     bubble,
    input  logic     hold,
    input  logic     flush,
    output id_ex_t   id_ex
);
    inst_t      ins;
    logic [2:0] f3;
    xlen_t      imm_i;
    xlen_t      imm_s;
    xlen_t      imm_b;
    xlen_t      imm_u;
    xlen_t      imm_j;
    ctrl_t      ctrl;
    xlen_t      imm;
    logic       use_rs1;
    logic       use_rs2;
    id_ex_t     id_next;

    // word selects the *W forms, alt the sub / arithmetic shift variant
    function automatic alu_op_e alu_of(input logic [2:0] fn, input logic alt, input logic word);
        case (fn)
            3'd0:    return word ? (alt ? ALU_SUBW : ALU_ADDW) : (alt ? ALU_SUB : ALU_ADD);
            3'd1:    return word ? ALU_SLLW : ALU_SLL;
            3'd2:    return ALU_SLT;
            3'd3:    return ALU_SLTU;
            3'd4:    return ALU_XOR;
            3'd5:    return word ? (alt ? ALU_SRAW : ALU_SRLW) : (alt ? ALU_SRA : ALU_SRL);
            3'd6:    return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    assign ins   = if_id.inst;
    assign f3    = ins[14:12];
    assign imm_i = {{52{ins[31]}}, ins[31:20]};
    assign imm_s = {{52{ins[31]}}, ins[31:25], ins[11:7]};
    assign imm_b = {{51{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
    assign imm_u = {{32{ins[31]}}, ins[31:12], 12'h000};
    assign imm_j = {{43{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};

    always_comb begin
        ctrl    = '0;
        imm     = '0;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        // opcode bit 3 marks the 32-bit forms
        case (ins[6:0])
            OPC_OP, OPC_OP_32: begin
                ctrl.alu_op = alu_of(f3, ins[30], ins[3]);
                ctrl.reg_we = 1'b1;
                use_rs1     = 1'b1;
                use_rs2     = 1'b1;
            end
            OPC_OP_IMM, OPC_OP_IMM_32: begin
                ctrl.alu_op = alu_of(f3, ins[30] && f3 == 3'd5, ins[3]);
                ctrl.b_imm  = 1'b1;
                ctrl.reg_we = 1'b1;
                use_rs1     = 1'b1;
                imm         = imm_i;
            end
            OPC_LOAD: begin
                ctrl.b_imm     = 1'b1;
                ctrl.reg_we    = 1'b1;
                ctrl.mem_re    = 1'b1;
                ctrl.wb_sel    = WB_MEM;
                ctrl.mem_width = mem_width_e'(f3);
                use_rs1        = 1'b1;
                imm            = imm_i;
            end
            OPC_STORE: begin
                ctrl.b_imm     = 1'b1;
                ctrl.mem_we    = 1'b1;
                ctrl.mem_width = mem_width_e'(f3);
                use_rs1        = 1'b1;
                use_rs2        = 1'b1;
                imm            = imm_s;
            end
            OPC_BRANCH: begin
                // alu forms pc + imm as the target
                ctrl.a_pc  = 1'b1;
                ctrl.b_imm = 1'b1;
                case (f3)
                    3'd0:    ctrl.br_op = BR_EQ;
                    3'd1:    ctrl.br_op = BR_NE;
                    3'd4:    ctrl.br_op = BR_LT;
                    3'd5:    ctrl.br_op = BR_GE;
                    3'd6:    ctrl.br_op = BR_LTU;
                    3'd7:    ctrl.br_op = BR_GEU;
                    default: ctrl.br_op = BR_NONE;
                endcase
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                imm     = imm_b;
            end
            OPC_JAL, OPC_JALR: begin
                ctrl.a_pc   = ins[3];
                ctrl.b_imm  = 1'b1;
                ctrl.br_op  = BR_JUMP;
                ctrl.reg_we = 1'b1;
                ctrl.wb_sel = WB_PC4;
                use_rs1     = !ins[3];
                imm         = ins[3] ? imm_j : imm_i;
            end
            OPC_LUI, OPC_AUIPC: begin
                // lui reads x0 as operand a
                ctrl.a_pc   = !ins[5];
                ctrl.b_imm  = 1'b1;
                ctrl.reg_we = 1'b1;
                imm         = imm_u;
            end
            default: ;
        endcase
    end

    // unused sources read as x0, keeps the hazard unit quiet
    assign rs1 = use_rs1 ? ins[19:15] : '0;
    assign rs2 = use_rs2 ? ins[24:20] : '0;

    always_comb begin
        id_next.valid   = if_id.valid;
        id_next.ctrl    = if_id.valid ? ctrl : '0;
        id_next.pc      = if_id.pc;
        id_next.inst    = ins;
        id_next.rs1     = rs1;
        id_next.rs2     = rs2;
        id_next.rd      = ins[11:7];
        id_next.imm     = imm;
        id_next.rs1_val = rs1_data;
        id_next.rs2_val = rs2_data;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            id_ex <= '0;
        end else if (flush) begin
            id_ex <= '0;
        end else if (!hold) begin
            id_ex <= bubble ? '0 : id_next;
        end
    end

endmodule

/* src/reg_file.sv */
`timescale 1ns/1ps

module reg_file import core_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    output xlen_t    rs1_data,
    output xlen_t    rs2_data,
    input  logic     we,
    input  reg_idx_t rd,
    input  xlen_t    rd_data
);
    xlen_t regs [32];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            regs <= '{default: '0};
        end else if (we && rd != '0) begin
            regs[rd] <= rd_data;
        end
    end

    // same-cycle writeback is visible to decode
    assign rs1_data = (rs1 == '0) ? '0 : (we && rd == rs1) ? rd_data : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : (we && rd == rs2) ? rd_data : regs[rs2];

endmodule

/* execute/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage import core_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  id_ex_t   id_ex,
    input  fwd_sel_t fwd_a,
    input  fwd_sel_t fwd_b,
    input  xlen_t    mem_fwd,
    input  xlen_t    wb_fwd,
    input  logic     hold,
    output logic     redirect,
    output xlen_t    target,
    output ex_mem_t  ex_mem
);
    xlen_t       rs1_v;
    xlen_t       rs2_v;
    xlen_t       op_a;
    xlen_t       op_b;
    logic [31:0] word_res;
    xlen_t       alu_res;
    logic        taken;
    byte_mask_t  base_mask;
    ex_mem_t     ex_next;

    function automatic xlen_t pick(input fwd_sel_t sel, input xlen_t reg_val,
                                   input xlen_t mem_val, input xlen_t wb_val);
        case (sel)
            FWD_MEM: return mem_val;
            FWD_WB:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

    assign rs1_v = pick(fwd_a, id_ex.rs1_val, mem_fwd, wb_fwd);
    assign rs2_v = pick(fwd_b, id_ex.rs2_val, mem_fwd, wb_fwd);
    assign op_a  = id_ex.ctrl.a_pc ? id_ex.pc : rs1_v;
    assign op_b  = id_ex.ctrl.b_imm ? id_ex.imm : rs2_v;

    // 32-bit half for the W forms
    always_comb begin
        case (id_ex.ctrl.alu_op)
            ALU_ADDW: word_res = op_a[31:0] + op_b[31:0];
            ALU_SUBW: word_res = op_a[31:0] - op_b[31:0];
            ALU_SLLW: word_res = op_a[31:0] << op_b[4:0];
            ALU_SRLW: word_res = op_a[31:0] >> op_b[4:0];
            default:  word_res = $signed(op_a[31:0]) >>> op_b[4:0];
        endcase
    end

    always_comb begin
        case (id_ex.ctrl.alu_op)
            ALU_ADD:  alu_res = op_a + op_b;
            ALU_SUB:  alu_res = op_a - op_b;
            ALU_SLL:  alu_res = op_a << op_b[5:0];
            ALU_SLT:  alu_res = {63'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: alu_res = {63'b0, op_a < op_b};
            ALU_XOR:  alu_res = op_a ^ op_b;
            ALU_SRL:  alu_res = op_a >> op_b[5:0];
            ALU_SRA:  alu_res = $signed(op_a) >>> op_b[5:0];
            ALU_OR:   alu_res = op_a | op_b;
            ALU_AND:  alu_res = op_a & op_b;
            default:  alu_res = {{32{word_res[31]}}, word_res};
        endcase
    end

    always_comb begin
        case (id_ex.ctrl.br_op)
            BR_EQ:   taken = rs1_v == rs2_v;
            BR_NE:   taken = rs1_v != rs2_v;
            BR_LT:   taken = $signed(rs1_v) < $signed(rs2_v);
            BR_GE:   taken = $signed(rs1_v) >= $signed(rs2_v);
            BR_LTU:  taken = rs1_v < rs2_v;
            BR_GEU:  taken = rs1_v >= rs2_v;
            BR_JUMP: taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    // a frozen EX must not steer fetch
    assign redirect = id_ex.valid && taken && !hold;
    assign target   = {alu_res[63:1], 1'b0};

    always_comb begin
        case (id_ex.ctrl.mem_width)
            MW_B:    base_mask = 8'h01;
            MW_H:    base_mask = 8'h03;
            MW_W:    base_mask = 8'h0f;
            default: base_mask = 8'hff;
        endcase
    end

    always_comb begin
        ex_next.valid  = id_ex.valid;
        ex_next.ctrl   = id_ex.ctrl;
        ex_next.pc     = id_ex.pc;
        ex_next.inst   = id_ex.inst;
        ex_next.rd     = id_ex.rd;
        ex_next.result = alu_res;
        // store data moved into its byte lane
        ex_next.wdata  = rs2_v << {alu_res[2:0], 3'b000};
        ex_next.wmask  = id_ex.ctrl.mem_we ? base_mask << alu_res[2:0] : '0;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_mem <= '0;
        end else if (!hold) begin
            ex_mem <= ex_next;
        end
    end

endmodule

/* src/mem_wb_stage.sv */
`timescale 1ns/1ps

module mem_wb_stage import core_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  ex_mem_t    ex_mem,
    input  logic       hold,
    output xlen_t      address,
    output logic       we_mem,
    output logic       re_mem,
    output xlen_t      wdata_mem,
    output byte_mask_t wmask_mem,
    input  xlen_t      rdata_mem,
    output xlen_t      mem_fwd,
    output logic       wb_we,
    output reg_idx_t   wb_rd,
    output xlen_t      wb_data,
    output commit_t    commit
);
    xlen_t   lane;
    xlen_t   load_val;
    commit_t wb_q;

    assign address   = ex_mem.result;
    assign we_mem    = ex_mem.valid && ex_mem.ctrl.mem_we;
    assign re_mem    = ex_mem.valid && ex_mem.ctrl.mem_re;
    assign wdata_mem = ex_mem.wdata;
    assign wmask_mem = ex_mem.wmask;

    // addressed byte moved down to bit 0
    assign lane = rdata_mem >> {ex_mem.result[2:0], 3'b000};

    always_comb begin
        case (ex_mem.ctrl.mem_width)
            MW_B:    load_val = {{56{lane[7]}}, lane[7:0]};
            MW_H:    load_val = {{48{lane[15]}}, lane[15:0]};
            MW_W:    load_val = {{32{lane[31]}}, lane[31:0]};
            MW_BU:   load_val = {56'b0, lane[7:0]};
            MW_HU:   load_val = {48'b0, lane[15:0]};
            MW_WU:   load_val = {32'b0, lane[31:0]};
            default: load_val = lane;
        endcase
    end

    // writeback value, also the MEM forwarding source
    always_comb begin
        case (ex_mem.ctrl.wb_sel)
            WB_MEM:  mem_fwd = load_val;
            WB_PC4:  mem_fwd = ex_mem.pc + 64'd4;
            default: mem_fwd = ex_mem.result;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_q <= '0;
        end else if (!hold) begin
            wb_q <= '{valid: ex_mem.valid, pc: ex_mem.pc, inst: ex_mem.inst, rd: ex_mem.rd,
                      rd_we: ex_mem.ctrl.reg_we, rd_data: mem_fwd};
        end
    end

    assign wb_we   = wb_q.valid && wb_q.rd_we;
    assign wb_rd   = wb_q.rd;
    assign wb_data = wb_q.rd_data;

    // a record held under a memory stall retires once, after the stall
    always_comb begin
        commit       = wb_q;
        commit.valid = wb_q.valid && !hold;
    end

endmodule

/* src/hazard_unit.sv */
`timescale 1ns/1ps

module hazard_unit import core_pkg::*; (
    input  id_ex_t   id_ex,
    input  ex_mem_t  ex_mem,
    input  reg_idx_t wb_rd,
    input  logic     wb_we,
    input  reg_idx_t dec_rs1,
    input  reg_idx_t dec_rs2,
    input  logic     if_stall,
    input  logic     mem_stall,
    input  logic     redirect,
    output fwd_sel_t fwd_a,
    output fwd_sel_t fwd_b,
    output logic     hold_front,
    output logic     hold_all,
    output logic     bubble,
    output logic     flush
);
    logic mem_wr;
    logic load_use;

    // youngest producer wins, x0 never forwarded
    function automatic fwd_sel_t fwd_for(input reg_idx_t src, input reg_idx_t mem_rd,
                                         input logic mem_ok, input reg_idx_t wrd,
                                         input logic wb_ok);
        if (src == '0) begin
            return FWD_REG;
        end
        if (mem_ok && mem_rd == src) begin
            return FWD_MEM;
        end
        if (wb_ok && wrd == src) begin
            return FWD_WB;
        end
        return FWD_REG;
    endfunction

    assign mem_wr = ex_mem.valid && ex_mem.ctrl.reg_we && ex_mem.rd != '0;
    assign fwd_a  = fwd_for(id_ex.rs1, ex_mem.rd, mem_wr, wb_rd, wb_we);
    assign fwd_b  = fwd_for(id_ex.rs2, ex_mem.rd, mem_wr, wb_rd, wb_we);

    // load in EX feeding the instruction in decode
    assign load_use = id_ex.valid && id_ex.ctrl.mem_re && id_ex.rd != '0 &&
                      (id_ex.rd == dec_rs1 || id_ex.rd == dec_rs2);

    assign hold_all   = mem_stall;
    assign hold_front = mem_stall || if_stall || load_use;
    assign bubble     = if_stall || load_use;
    assign flush      = redirect;

endmodule

/* src/core_top.sv */
`timescale 1ns/1ps

module core_top import core_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    output xlen_t      pc,
    input  inst_t      inst,
    input  logic       if_stall,
    output xlen_t      address,
    output logic       we_mem,
    output logic       re_mem,
    output xlen_t      wdata_mem,
    output byte_mask_t wmask_mem,
    input  xlen_t      rdata_mem,
    input  logic       mem_stall,
    output commit_t    commit
);
    if_id_t   if_id;
    id_ex_t   id_ex;
    ex_mem_t  ex_mem;
    reg_idx_t rs1;
    reg_idx_t rs2;
    xlen_t    rs1_data;
    xlen_t    rs2_data;
    fwd_sel_t fwd_a;
    fwd_sel_t fwd_b;
    xlen_t    mem_fwd;
    logic     wb_we;
    reg_idx_t wb_rd;
    xlen_t    wb_data;
    logic     redirect;
    xlen_t    target;
    logic     hold_front;
    logic     hold_all;
    logic     bubble;
    logic     flush;

    fetch_stage fetch_i (
        .clk(clk), .arst_n(arst_n), .hold(hold_front), .flush(flush),
        .redirect(redirect), .target(target), .pc(pc), .inst(inst), .if_id(if_id)
    );

    decoder decoder_i (
        .clk(clk), .arst_n(arst_n), .if_id(if_id), .rs1_data(rs1_data),
        .rs2_data(rs2_data), .rs1(rs1), .rs2(rs2), .bubble(bubble),
        .hold(hold_all), .flush(flush), .id_ex(id_ex)
    );

    reg_file reg_file_i (
        .clk(clk), .arst_n(arst_n), .rs1(rs1), .rs2(rs2), .rs1_data(rs1_data),
        .rs2_data(rs2_data), .we(wb_we), .rd(wb_rd), .rd_data(wb_data)
    );

    execute_stage execute_i (
        .clk(clk), .arst_n(arst_n), .id_ex(id_ex), .fwd_a(fwd_a), .fwd_b(fwd_b),
        .mem_fwd(mem_fwd), .wb_fwd(wb_data), .hold(hold_all), .redirect(redirect),
        .target(target), .ex_mem(ex_mem)
    );

    mem_wb_stage mem_wb_i (
        .clk(clk), .arst_n(arst_n), .ex_mem(ex_mem), .hold(hold_all),
        .address(address), .we_mem(we_mem), .re_mem(re_mem), .wdata_mem(wdata_mem),
        .wmask_mem(wmask_mem), .rdata_mem(rdata_mem), .mem_fwd(mem_fwd),
        .wb_we(wb_we), .wb_rd(wb_rd), .wb_data(wb_data), .commit(commit)
    );

    hazard_unit hazard_i (
        .id_ex(id_ex), .ex_mem(ex_mem), .wb_rd(wb_rd), .wb_we(wb_we),
        .dec_rs1(rs1), .dec_rs2(rs2), .if_stall(if_stall), .mem_stall(mem_stall),
        .redirect(redirect), .fwd_a(fwd_a), .fwd_b(fwd_b), .hold_front(hold_front),
        .hold_all(hold_all), .bubble(bubble), .flush(flush)
    );

endmodule

/* test/core_assert.sv */
`timescale 1ns/1ps

module core_assert import core_pkg::*; (
    input logic       clk,
    input logic       arst_n,
    input commit_t    commit,
    input logic       we_mem,
    input logic       re_mem,
    input xlen_t      address,
    input xlen_t      wdata_mem,
    input byte_mask_t wmask_mem,
    input logic       mem_stall
);
    localparam int N_COMMITS = 12;

    xlen_t    exp_pc   [N_COMMITS];
    inst_t    exp_inst [N_COMMITS];
    reg_idx_t exp_rd   [N_COMMITS];
    logic     exp_we   [N_COMMITS];
    xlen_t    exp_data [N_COMMITS];
    int       commit_count;
    int       reset_cycles;
    int       error_count = 0;

    task automatic entry(input int i, input xlen_t pc, input inst_t ins, input reg_idx_t rd,
                         input logic we, input xlen_t data);
        exp_pc[i]   = pc;
        exp_inst[i] = ins;
        exp_rd[i]   = rd;
        exp_we[i]   = we;
        exp_data[i] = data;
    endtask

    // hand-worked RV64I results of the program in core_tb
    initial begin
        entry(0,  64'h00, 32'h0050_0093, 5'd1,  1'b1, 64'd5);
        entry(1,  64'h04, 32'h0030_8113, 5'd2,  1'b1, 64'd8);
        entry(2,  64'h08, 32'h0020_81b3, 5'd3,  1'b1, 64'd13);
        entry(3,  64'h0c, 32'hfec1_821b, 5'd4,  1'b1, 64'hffff_ffff_ffff_fff9);
        entry(4,  64'h10, 32'h4012_02bb, 5'd5,  1'b1, 64'hffff_ffff_ffff_fff4);
        entry(5,  64'h14, 32'h0050_01a3, 5'd0,  1'b0, 64'h0);
        entry(6,  64'h18, 32'h0030_0303, 5'd6,  1'b1, 64'hffff_ffff_ffff_fff4);
        entry(7,  64'h1c, 32'h0013_03b3, 5'd7,  1'b1, 64'hffff_ffff_ffff_fff9);
        entry(8,  64'h20, 32'h0000_3403, 5'd8,  1'b1, 64'h0101_0101_f401_0101);
        entry(9,  64'h24, 32'h0010_8663, 5'd0,  1'b0, 64'h0);
        entry(10, 64'h30, 32'h00c0_056f, 5'd10, 1'b1, 64'h34);
        entry(11, 64'h3c, 32'h0015_0613, 5'd12, 1'b1, 64'h35);
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            commit_count <= 0;
            reset_cycles <= 0;
        end else begin
            if (commit.valid && commit_count < N_COMMITS) begin
                commit_count <= commit_count + 1;
            end
            if (reset_cycles < 8) begin
                reset_cycles <= reset_cycles + 1;
            end
        end
    end

    // first instruction needs 4 cycles to reach writeback
    a_quiet: assert property (@(posedge clk) disable iff (!arst_n)
        reset_cycles < 4 |-> !commit.valid && !we_mem && !re_mem)
        else begin
            error_count++;
            $error("commit or memory access within 4 cycles of reset");
        end

    a_pc: assert property (@(posedge clk) disable iff (!arst_n)
        commit.valid && commit_count < N_COMMITS |-> commit.pc == exp_pc[commit_count])
        else begin
            error_count++;
            $error("Mismatch commit_pc entry %0d expected %h actual %h",
                   $sampled(commit_count), exp_pc[$sampled(commit_count)],
                   $sampled(commit.pc));
        end

    a_inst: assert property (@(posedge clk) disable iff (!arst_n)
        commit.valid && commit_count < N_COMMITS |-> commit.inst == exp_inst[commit_count])
        else begin
            error_count++;
            $error("Mismatch commit_inst entry %0d expected %h actual %h",
                   $sampled(commit_count), exp_inst[$sampled(commit_count)],
                   $sampled(commit.inst));
        end

    a_rd: assert property (@(posedge clk) disable iff (!arst_n)
        commit.valid && commit_count < N_COMMITS |->
        commit.rd_we == exp_we[commit_count] &&
        (!exp_we[commit_count] || commit.rd == exp_rd[commit_count]))
        else begin
            error_count++;
            $error("Mismatch commit_rd entry %0d expected we %0b rd %0d actual we %0b rd %0d",
                   $sampled(commit_count), exp_we[$sampled(commit_count)],
                   exp_rd[$sampled(commit_count)], $sampled(commit.rd_we),
                   $sampled(commit.rd));
        end

    a_data: assert property (@(posedge clk) disable iff (!arst_n)
        commit.valid && commit_count < N_COMMITS && exp_we[commit_count] |->
        commit.rd_data == exp_data[commit_count])
        else begin
            error_count++;
            $error("Mismatch commit_data entry %0d expected %h actual %h",
                   $sampled(commit_count), exp_data[$sampled(commit_count)],
                   $sampled(commit.rd_data));
        end

    // sb to address 3 lands in byte lane 3
    a_store: assert property (@(posedge clk) disable iff (!arst_n)
        we_mem && address == 64'h3 |-> wmask_mem == 8'h08 && wdata_mem[31:24] == 8'hf4)
        else begin
            error_count++;
            $error("Mismatch store_lane expected %h actual %h", {8'h08, 8'hf4},
                   {$sampled(wmask_mem), $sampled(wdata_mem[31:24])});
        end

    a_no_commit_in_stall: assert property (@(posedge clk) disable iff (!arst_n)
        mem_stall |-> !commit.valid)
        else begin
            error_count++;
            $error("commit retired while the data memory stalled");
        end

endmodule

bind core_top core_assert core_assert_i (
    .clk(clk), .arst_n(arst_n), .commit(commit), .we_mem(we_mem), .re_mem(re_mem),
    .address(address), .wdata_mem(wdata_mem), .wmask_mem(wmask_mem), .mem_stall(mem_stall)
);

/* test/core_tb.sv */
`timescale 1ns/1ps

module core_tb;
    import core_pkg::*;

    localparam int TIMEOUT_CYCLES = 400;
    localparam int N_COMMITS      = 12;

    logic       clk;
    logic       arst_n;
    xlen_t      pc;
    inst_t      inst;
    logic       if_stall;
    xlen_t      address;
    logic       we_mem;
    logic       re_mem;
    xlen_t      wdata_mem;
    byte_mask_t wmask_mem;
    xlen_t      rdata_mem;
    logic       mem_stall;
    commit_t    commit;

    inst_t  imem [64];
    xlen_t  dmem [64];
    integer seed;
    logic   stall_en;
    int     cycles;
    int     commits_seen;

    core_top dut_i (
        .clk(clk), .arst_n(arst_n), .pc(pc), .inst(inst), .if_stall(if_stall),
        .address(address), .we_mem(we_mem), .re_mem(re_mem), .wdata_mem(wdata_mem),
        .wmask_mem(wmask_mem), .rdata_mem(rdata_mem), .mem_stall(mem_stall),
        .commit(commit)
    );

    // combinational memories
    assign inst      = imem[pc[7:2]];
    assign rdata_mem = dmem[address[8:3]];

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic load_program();
        for (int i = 0; i < 64; i++) begin
            imem[i] = NOP_INST;
        end
        imem[0]  = 32'h0050_0093;  // addi  x1, x0, 5
        imem[1]  = 32'h0030_8113;  // addi  x2, x1, 3
        imem[2]  = 32'h0020_81b3;  // add   x3, x1, x2
        imem[3]  = 32'hfec1_821b;  // addiw x4, x3, -20
        imem[4]  = 32'h4012_02bb;  // subw  x5, x4, x1
        imem[5]  = 32'h0050_01a3;  // sb    x5, 3(x0)
        imem[6]  = 32'h0030_0303;  // lb    x6, 3(x0)
        imem[7]  = 32'h0013_03b3;  // add   x7, x6, x1
        imem[8]  = 32'h0000_3403;  // ld    x8, 0(x0)
        imem[9]  = 32'h0010_8663;  // beq   x1, x1, +12
        imem[10] = 32'h0010_0493;  // addi  x9, x0, 1
        imem[11] = 32'h0020_0493;  // addi  x9, x0, 2
        imem[12] = 32'h00c0_056f;  // jal   x10, +12
        imem[13] = 32'h0010_0593;  // addi  x11, x0, 1
        imem[14] = 32'h0020_0593;  // addi  x11, x0, 2
        imem[15] = 32'h0015_0613;  // addi  x12, x10, 1
        imem[16] = 32'h0000_006f;  // jal   x0, 0
    endtask

    task automatic fill_data();
        for (int i = 0; i < 64; i++) begin
            dmem[i] = 64'h0101_0101_0101_0101 * (i + 1);
        end
    endtask

    // byte-masked write, held off while the memory stalls
    always @(posedge clk) begin
        if (we_mem && !mem_stall) begin
            for (int b = 0; b < 8; b++) begin
                if (wmask_mem[b]) begin
                    dmem[address[8:3]][b*8 +: 8] <= wdata_mem[b*8 +: 8];
                end
            end
        end
    end

    always @(negedge clk) begin
        if (stall_en && arst_n) begin
            if_stall  <= ($random(seed) & 3) == 0;
            mem_stall <= ($random(seed) & 3) == 0;
        end else begin
            if_stall  <= 1'b0;
            mem_stall <= 1'b0;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, commit table not completed", cycles);
            $display("Checks failed");
            $finish;
        end
    end

    task automatic run_program();
        fill_data();
        arst_n <= 1'b0;
        repeat (8) @(negedge clk);
        arst_n <= 1'b1;
        while (dut_i.core_assert_i.commit_count != N_COMMITS) begin
            @(negedge clk);
        end
        commits_seen += dut_i.core_assert_i.commit_count;
        repeat (2) @(negedge clk);
    endtask

    initial begin
        seed         = 32'h8ebb_9750;
        arst_n       = 1'b0;
        if_stall     = 1'b0;
        mem_stall    = 1'b0;
        stall_en     = 1'b0;
        cycles       = 0;
        commits_seen = 0;
        load_program();
        fill_data();

        // stall-free pass, then the same program under random stalls
        run_program();
        stall_en <= 1'b1;
        run_program();

        $display("commits checked %0d, errors %0d", commits_seen,
                 dut_i.core_assert_i.error_count);
        if (dut_i.core_assert_i.error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* build.f */
common/core_pkg.sv
src/fetch_stage.sv
decode/decoder.sv
src/reg_file.sv
execute/execute_stage.sv
src/mem_wb_stage.sv
src/hazard_unit.sv
src/core_top.sv
test/core_assert.sv
test/core_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --assert --timing
TOP       = core_tb
FILELIST  = build.f
OBJ_DIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qx "All checks passed"

clean:
	rm -rf $(OBJ_DIR)
